// File: mem_subsys.f
verilog/rv32_isa_pkg.sv
verilog/dmem_pkg.sv
verilog/mem_align.sv
verilog/amo_unit.sv
verilog/mem_stage.sv
verilog/dmem_ram.sv
verilog/mem_subsys.sv
tests/mem_subsys_sva.sv
tests/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - verilog/rv32_isa_pkg.sv
  - verilog/dmem_pkg.sv
  - verilog/mem_align.sv
  - verilog/amo_unit.sv
  - verilog/mem_stage.sv
  - verilog/dmem_ram.sv
  - verilog/mem_subsys.sv
  - target: test
    files:
      - tests/mem_subsys_sva.sv
      - tests/mem_subsys_tb.sv

// File: tests/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb;

localparam int dmem_words      = 256;
localparam int dmem_latency    = 2;
localparam int clk_period      = 8;
localparam int region_words    = 16;    // words the tests touch, at byte addresses 0x00..0x3c
localparam int n_ops           = 130;   // upper bound on instructions over all tests
localparam int watchdog_cycles = 2 * n_ops * (3 + 2 * dmem_latency) + 40;

logic                      clk;
logic                      rst;
logic                      in_valid;
logic [6:0]                opcode;
logic [2:0]                funct3;
logic [4:0]                funct5;
logic [dmem_pkg::xlen-1:0] addr;
logic [dmem_pkg::xlen-1:0] rs2_v;
logic [4:0]                rd_s;
logic                      stall;
logic                      wb_valid;
logic [4:0]                wb_rd_s;
logic [dmem_pkg::xlen-1:0] wb_data;
logic                      lock;
logic [dmem_pkg::xlen-1:0] locked_address;

logic [dmem_pkg::xlen-1:0] shadow [region_words];   // expected memory contents
logic                      res_valid;               // expected reservation
logic [dmem_pkg::xlen-1:0] res_addr;
logic [15:0]               lfsr = 16'd24316;
int                        error_count = 0;

initial clk = 1'b0;
always #(clk_period / 2) clk = ~clk;

mem_subsys #(
    .dmem_words   (dmem_words),
    .dmem_latency (dmem_latency)
) i_mem_subsys (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .opcode         (opcode),
    .funct3         (funct3),
    .funct5         (funct5),
    .addr           (addr),
    .rs2_v          (rs2_v),
    .rd_s           (rd_s),
    .stall          (stall),
    .wb_valid       (wb_valid),
    .wb_rd_s        (wb_rd_s),
    .wb_data        (wb_data),
    .lock           (lock),
    .locked_address (locked_address)
);

// galois lfsr, x^16+x^14+x^13+x^11+1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 16'hb400 : 16'h0000);
        r    = {r[30:0], b};
    end
    return r;
endfunction

function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h6b3d_91c5;
endfunction

function automatic logic [31:0] extract_load(input logic [31:0] word, input logic [2:0] f3,
                                             input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(word >> (8 * off));
    h = 16'(word >> (8 * off));
    case (f3)
        rv32_isa_pkg::f3_lb:  return {{24{b[7]}}, b};
        rv32_isa_pkg::f3_lbu: return {24'h0, b};
        rv32_isa_pkg::f3_lh:  return {{16{h[15]}}, h};
        rv32_isa_pkg::f3_lhu: return {16'h0, h};
        default:              return word;
    endcase
endfunction

function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
                                            input logic [2:0] f3, input logic [1:0] off);
    logic [31:0] lanes;
    case (f3)
        rv32_isa_pkg::f3_sb: lanes = 32'h0000_00ff << (8 * off);
        rv32_isa_pkg::f3_sh: lanes = 32'h0000_ffff << (8 * off);
        default:             lanes = 32'hffff_ffff;
    endcase
    return (old & ~lanes) | ((data << (8 * off)) & lanes);
endfunction

function automatic logic [31:0] amo_result(input logic [4:0] f5, input logic [31:0] old,
                                           input logic [31:0] v);
    case (f5)
        rv32_isa_pkg::amo_add:  return old + v;
        rv32_isa_pkg::amo_xor:  return old ^ v;
        rv32_isa_pkg::amo_and:  return old & v;
        rv32_isa_pkg::amo_or:   return old | v;
        rv32_isa_pkg::amo_min:  return ($signed(old) < $signed(v)) ? old : v;
        rv32_isa_pkg::amo_max:  return ($signed(old) < $signed(v)) ? v : old;
        rv32_isa_pkg::amo_minu: return (old < v) ? old : v;
        rv32_isa_pkg::amo_maxu: return (old < v) ? v : old;
        default:                return v;   // swap
    endcase
endfunction

// cycles from acceptance to wb_valid
function automatic int expected_cycles(input logic [6:0] op, input logic [4:0] f5,
                                       input logic sc_ok);
    if (op != rv32_isa_pkg::op_amo || f5 == rv32_isa_pkg::amo_lr)
        return 1 + dmem_latency;
    if (f5 == rv32_isa_pkg::amo_sc)
        return sc_ok ? 1 + dmem_latency : 1;
    return 2 + 2 * dmem_latency;
endfunction

task automatic abort_run(input string why);
    error_count++;
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
        abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time));
endtask

// drives one instruction, waits for writeback and updates the shadow model
task automatic run_op(input logic [6:0] op, input logic [2:0] f3, input logic [4:0] f5,
                      input logic [31:0] a, input logic [31:0] data);
    int          idx;
    int          cycles;
    int          want_cycles;
    logic        sc_ok;
    logic [31:0] word;
    logic [31:0] old;
    logic [31:0] want_wb;
    logic [4:0]  dest;
    idx         = a[5:2];
    word        = {a[31:2], 2'b00};
    old         = shadow[idx];
    sc_ok       = res_valid && (res_addr == word);
    dest        = 5'(rand_bits(5));
    want_cycles = expected_cycles(op, f5, sc_ok);
    want_wb     = '0;
    if (op == rv32_isa_pkg::op_load)
        want_wb = extract_load(old, f3, a[1:0]);
    else if (op == rv32_isa_pkg::op_store)
        shadow[idx] = merge_store(old, data, f3, a[1:0]);
    else if (f5 == rv32_isa_pkg::amo_lr)
        want_wb = old;
    else if (f5 == rv32_isa_pkg::amo_sc)
    begin
        want_wb = sc_ok ? 32'd0 : 32'd1;
        if (sc_ok)
            shadow[idx] = data;
    end
    else
    begin
        want_wb     = old;
        shadow[idx] = amo_result(f5, old, data);
    end
    if (op == rv32_isa_pkg::op_amo && f5 == rv32_isa_pkg::amo_lr)
    begin
        res_valid = 1'b1;
        res_addr  = word;
    end
    else if (op == rv32_isa_pkg::op_amo && f5 == rv32_isa_pkg::amo_sc)
        res_valid = 1'b0;
    else if (op != rv32_isa_pkg::op_load && res_addr == word)
        res_valid = 1'b0;   // any write to the reserved word
    in_valid = 1'b1;
    opcode   = op;
    funct3   = f3;
    funct5   = f5;
    addr     = a;
    rs2_v    = data;
    rd_s     = dest;
    cycles   = 0;
    @(negedge clk);
    while (wb_valid !== 1'b1)
    begin
        assert (stall === 1'b1) else abort_run("stall dropped before the instruction completed");
        assert (cycles < 4 * want_cycles + 8) else abort_run("no wb_valid from the memory stage");
        cycles++;
        @(negedge clk);
    end
    check_value("stall", stall, 32'd0);
    check_value("wb_valid delay", cycles, want_cycles);
    check_value("wb_rd_s", wb_rd_s, dest);
    check_value("wb_data", wb_data, want_wb);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    check_value("lock", lock, res_valid);
    if (res_valid)
        check_value("locked_address", locked_address, res_addr);
endtask

task automatic fill_memory();
    for (int i = 0; i < region_words; i++)
        run_op(rv32_isa_pkg::op_store, rv32_isa_pkg::f3_sw, 5'd0, i * 4, fill_pattern(i * 4));
endtask

task automatic check_store_load();
    logic [31:0] base;
    logic [2:0]  st_f3;
    logic [2:0]  ld_f3;
    for (int round = 0; round < 2; round++)
        for (int w = 0; w < 3; w++)     // byte, half, word
            for (int off = 0; off < 4; off += (1 << w))
            begin
                base  = rand_bits(4) << 2;
                st_f3 = (w == 0) ? rv32_isa_pkg::f3_sb : (w == 1) ? rv32_isa_pkg::f3_sh
                                                                  : rv32_isa_pkg::f3_sw;
                ld_f3 = (w == 0) ? rv32_isa_pkg::f3_lb : (w == 1) ? rv32_isa_pkg::f3_lh
                                                                  : rv32_isa_pkg::f3_lw;
                run_op(rv32_isa_pkg::op_store, st_f3, 5'd0, base + off, rand_bits(32));
                run_op(rv32_isa_pkg::op_load, ld_f3, 5'd0, base + off, 32'd0);
                if (w == 0)
                    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lbu, 5'd0, base + off, 32'd0);
                if (w == 1)
                    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lhu, 5'd0, base + off, 32'd0);
                // neighbour lanes must be untouched
                run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, base, 32'd0);
            end
endtask

task automatic check_load_latency();
    repeat (4)
        run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, rand_bits(4) << 2, 32'd0);
endtask

task automatic check_amo_ops();
    logic [4:0]  ops [9] = '{rv32_isa_pkg::amo_swap, rv32_isa_pkg::amo_add, rv32_isa_pkg::amo_xor,
                             rv32_isa_pkg::amo_and, rv32_isa_pkg::amo_or, rv32_isa_pkg::amo_min,
                             rv32_isa_pkg::amo_max, rv32_isa_pkg::amo_minu,
                             rv32_isa_pkg::amo_maxu};
    logic [31:0] a;
    for (int i = 0; i < 9; i++)
    begin
        a = rand_bits(4) << 2;
        run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, ops[i], a, rand_bits(32));
        run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, a, 32'd0);
    end
    // signed and unsigned compares disagree on these
    run_op(rv32_isa_pkg::op_store, rv32_isa_pkg::f3_sw, 5'd0, 32'h20, 32'hffff_fff0);
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_max, 32'h20, 32'd5);
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_min, 32'h20, 32'hffff_0000);
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_maxu, 32'h20, 32'h7fff_ffff);
    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, 32'h20, 32'd0);
endtask

task automatic check_reservation();
    logic [31:0] a;
    logic [31:0] b;
    a = rand_bits(4) << 2;
    b = a ^ 32'h4;  // a different word
    // lr then sc on the same word succeeds
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_lr, a, 32'd0);
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_sc, a, rand_bits(32));
    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, a, 32'd0);
    // a store elsewhere keeps the reservation
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_lr, a, 32'd0);
    run_op(rv32_isa_pkg::op_store, rv32_isa_pkg::f3_sw, 5'd0, b, rand_bits(32));
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_sc, a, rand_bits(32));
    // a byte store to the reserved word breaks it
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_lr, a, 32'd0);
    run_op(rv32_isa_pkg::op_store, rv32_isa_pkg::f3_sb, 5'd0, a + 1, rand_bits(32));
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_sc, a, rand_bits(32));
    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, a, 32'd0);
    // sc with no lr at all
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_sc, b, rand_bits(32));
    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, b, 32'd0);
    // sc to another word fails and still drops the lock
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_lr, a, 32'd0);
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_sc, b, rand_bits(32));
    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, b, 32'd0);
    // amo write to the reserved word
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_lr, b, 32'd0);
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_add, b, rand_bits(32));
    run_op(rv32_isa_pkg::op_amo, rv32_isa_pkg::f3_sw, rv32_isa_pkg::amo_sc, b, rand_bits(32));
    run_op(rv32_isa_pkg::op_load, rv32_isa_pkg::f3_lw, 5'd0, b, 32'd0);
endtask

initial
begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    opcode    = '0;
    funct3    = '0;
    funct5    = '0;
    addr      = '0;
    rs2_v     = '0;
    rd_s      = '0;
    res_valid = 1'b0;
    res_addr  = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    check_value("stall", stall, 32'd0);
    check_value("wb_valid", wb_valid, 32'd0);
    check_value("lock", lock, 32'd0);
    fill_memory();
    check_store_load();
    check_load_latency();
    check_amo_ops();
    check_reservation();
    if (error_count == 0)
        $display("=== PASS ===");
    else
        $display("=== FAIL ===");
    $finish;
end

initial
begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before all tests completed");
    $display("=== FAIL ===");
    $fatal(1, "timeout");
end

endmodule

// File: tests/mem_subsys_sva.sv
`timescale 1ns/10ps

module mem_subsys_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        stall,
    input logic                        wb_valid,
    input logic                        lock,
    input logic [dmem_pkg::mask_w-1:0] dmem_rmask,
    input logic [dmem_pkg::mask_w-1:0] dmem_wmask
);

logic req;

assign req = (dmem_rmask != '0) || (dmem_wmask != '0);

// stage is idle on the first edge after reset is released
a_idle_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !stall && !wb_valid && !lock && !req)
    else $error("memory stage not idle after reset");

// one-shot request, never held into the next cycle
a_req_one_cycle: assert property (@(posedge clk) disable iff (rst)
    req |=> !req)
    else $error("dmem request held for more than one cycle");

a_no_read_and_write: assert property (@(posedge clk) disable iff (rst)
    !((dmem_rmask != '0) && (dmem_wmask != '0)))
    else $error("dmem read and write mask active together");

endmodule

bind mem_stage mem_subsys_sva i_mem_subsys_sva (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .wb_valid   (wb_valid),
    .lock       (lock),
    .dmem_rmask (dmem_rmask),
    .dmem_wmask (dmem_wmask)
);

// File: verilog/mem_subsys.sv
`timescale 1ns/10ps

module mem_subsys #(
    parameter int dmem_words   = 256,
    parameter int dmem_latency = 2   // cycles from request to resp, at least 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [6:0]                opcode,
    input  logic [2:0]                funct3,
    input  logic [4:0]                funct5,
    input  logic [dmem_pkg::xlen-1:0] addr,
    input  logic [dmem_pkg::xlen-1:0] rs2_v,
    input  logic [4:0]                rd_s,
    output logic                      stall,
    output logic                      wb_valid,
    output logic [4:0]                wb_rd_s,
    output logic [dmem_pkg::xlen-1:0] wb_data,
    output logic                      lock,
    output logic [dmem_pkg::xlen-1:0] locked_address
);

// dmem bus between the stage and the ram
logic [dmem_pkg::xlen-1:0]   dmem_addr;
logic [dmem_pkg::mask_w-1:0] dmem_rmask;
logic [dmem_pkg::mask_w-1:0] dmem_wmask;
logic [dmem_pkg::xlen-1:0]   dmem_wdata;
logic [dmem_pkg::xlen-1:0]   dmem_rdata;
logic                        dmem_resp;

mem_stage i_mem_stage (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .opcode         (opcode),
    .funct3         (funct3),
    .funct5         (funct5),
    .addr           (addr),
    .rs2_v          (rs2_v),
    .rd_s           (rd_s),
    .dmem_rdata     (dmem_rdata),
    .dmem_resp      (dmem_resp),
    .dmem_addr      (dmem_addr),
    .dmem_rmask     (dmem_rmask),
    .dmem_wmask     (dmem_wmask),
    .dmem_wdata     (dmem_wdata),
    .stall          (stall),
    .wb_valid       (wb_valid),
    .wb_rd_s        (wb_rd_s),
    .wb_data        (wb_data),
    .lock           (lock),
    .locked_address (locked_address)
);

dmem_ram #(
    .dmem_words   (dmem_words),
    .dmem_latency (dmem_latency)
) i_dmem_ram (
    .clk   (clk),
    .rst   (rst),
    .addr  (dmem_addr),
    .rmask (dmem_rmask),
    .wmask (dmem_wmask),
    .wdata (dmem_wdata),
    .rdata (dmem_rdata),
    .resp  (dmem_resp)
);

endmodule

// File: verilog/dmem_ram.sv
`timescale 1ns/10ps

module dmem_ram #(
    parameter int dmem_words   = 256,
    parameter int dmem_latency = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [dmem_pkg::xlen-1:0]   addr,
    input  logic [dmem_pkg::mask_w-1:0] rmask,
    input  logic [dmem_pkg::mask_w-1:0] wmask,
    input  logic [dmem_pkg::xlen-1:0]   wdata,
    output logic [dmem_pkg::xlen-1:0]   rdata,
    output logic                        resp
);

localparam int aw = $clog2(dmem_words);

logic [dmem_pkg::xlen-1:0] mem [dmem_words];
logic [aw-1:0]             idx;
logic                      req;
logic [dmem_latency-1:0]   resp_pipe;
logic [dmem_pkg::xlen-1:0] data_pipe [dmem_latency];

assign idx = addr[aw+1:2];  // word index, byte offset dropped
assign req = (rmask != '0) || (wmask != '0);

always_ff @(posedge clk)
begin
    for (int b = 0; b < dmem_pkg::mask_w; b++)
    begin
        if (wmask[b])
            mem[idx][8*b +: 8] <= wdata[8*b +: 8];
    end
end

// word is captured before this cycle's write lands
always_ff @(posedge clk)
begin
    data_pipe[0] <= mem[idx];
    for (int i = 1; i < dmem_latency; i++)
        data_pipe[i] <= data_pipe[i-1];
end

always_ff @(posedge clk)
begin
    if (rst)
        resp_pipe <= '0;
    else
    begin
        resp_pipe[0] <= req;
        for (int i = 1; i < dmem_latency; i++)
            resp_pipe[i] <= resp_pipe[i-1];
    end
end

assign resp  = resp_pipe[dmem_latency-1];
assign rdata = data_pipe[dmem_latency-1];

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [6:0]                  opcode,
    input  logic [2:0]                  funct3,
    input  logic [4:0]                  funct5,
    input  logic [dmem_pkg::xlen-1:0]   addr,
    input  logic [dmem_pkg::xlen-1:0]   rs2_v,
    input  logic [4:0]                  rd_s,
    input  logic [dmem_pkg::xlen-1:0]   dmem_rdata,
    input  logic                        dmem_resp,
    output logic [dmem_pkg::xlen-1:0]   dmem_addr,
    output logic [dmem_pkg::mask_w-1:0] dmem_rmask,
    output logic [dmem_pkg::mask_w-1:0] dmem_wmask,
    output logic [dmem_pkg::xlen-1:0]   dmem_wdata,
    output logic                        stall,
    output logic                        wb_valid,
    output logic [4:0]                  wb_rd_s,
    output logic [dmem_pkg::xlen-1:0]   wb_data,
    output logic                        lock,
    output logic [dmem_pkg::xlen-1:0]   locked_address
);

logic is_load;
logic is_store;
logic is_amo;
logic active;   // instruction has been seen for at least one edge
logic issued;   // one-shot, request already went out
logic go;
logic mem_done;
logic done;
logic rd_fire;
logic wr_fire;
logic [dmem_pkg::xlen-1:0]   word_addr;
logic [dmem_pkg::xlen-1:0]   wdata;
logic [dmem_pkg::xlen-1:0]   load_data;
logic [dmem_pkg::xlen-1:0]   amo_wr_data;
logic [dmem_pkg::xlen-1:0]   amo_old;
logic [dmem_pkg::mask_w-1:0] rmask;
logic [dmem_pkg::mask_w-1:0] wmask;
logic amo_rd_req;
logic amo_wr_req;
logic amo_done;
logic sc_fail;

assign is_load  = (opcode == rv32_isa_pkg::op_load);
assign is_store = (opcode == rv32_isa_pkg::op_store);
assign is_amo   = (opcode == rv32_isa_pkg::op_amo);

assign go = in_valid && active && !issued; // first cycle after acceptance

always_comb
begin
    if (is_amo)
        mem_done = amo_done;
    else if (is_load || is_store)
        mem_done = issued && dmem_resp;
    else
        mem_done = go;  // not a memory op, just pass it through
end

assign done  = in_valid && active && mem_done;
assign stall = in_valid && !done;

always_ff @(posedge clk)
begin
    if (rst)
    begin
        active <= 1'b0;
        issued <= 1'b0;
    end
    else if (done)
    begin
        active <= 1'b0;
        issued <= 1'b0;
    end
    else
    begin
        if (in_valid)
            active <= 1'b1;
        if (go)
            issued <= 1'b1;
    end
end

// atomics sequence their own requests
assign rd_fire = is_amo ? amo_rd_req : (go && is_load);
assign wr_fire = is_amo ? amo_wr_req : (go && is_store);

assign dmem_addr  = (rd_fire || wr_fire) ? word_addr : '0;
assign dmem_rmask = rd_fire ? rmask : '0;
assign dmem_wmask = wr_fire ? wmask : '0;
assign dmem_wdata = wr_fire ? wdata : '0;

assign wb_valid = done;
assign wb_rd_s  = rd_s;

always_comb
begin
    if (is_load)
        wb_data = load_data;
    else if (is_amo && (funct5 == rv32_isa_pkg::amo_sc))
        wb_data = {{(dmem_pkg::xlen-1){1'b0}}, sc_fail};
    else if (is_amo)
        wb_data = amo_old;
    else
        wb_data = '0;   // stores write nothing back
end

mem_align i_mem_align (
    .opcode    (opcode),
    .funct3    (funct3),
    .funct5    (funct5),
    .addr      (addr),
    .rs2_v     (rs2_v),
    .rdata_raw (dmem_rdata),
    .amo_wdata (amo_wr_data),
    .word_addr (word_addr),
    .rmask     (rmask),
    .wmask     (wmask),
    .wdata     (wdata),
    .load_data (load_data)
);

amo_unit i_amo_unit (
    .clk            (clk),
    .rst            (rst),
    .start          (go && is_amo),
    .funct5         (funct5),
    .word_addr      (word_addr),
    .operand        (rs2_v),
    .rdata          (dmem_rdata),
    .resp           (dmem_resp),
    .store_seen     (|dmem_wmask),  // any write can break the reservation
    .store_addr     (dmem_addr),
    .rd_req         (amo_rd_req),
    .wr_req         (amo_wr_req),
    .wr_data        (amo_wr_data),
    .old_data       (amo_old),
    .done           (amo_done),
    .sc_fail        (sc_fail),
    .lock           (lock),
    .locked_address (locked_address)
);

endmodule

// File: verilog/amo_unit.sv
`timescale 1ns/10ps

module amo_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [4:0]  funct5,
    input  logic [31:0] word_addr,
    input  logic [31:0] operand,
    input  logic [31:0] rdata,
    input  logic        resp,
    input  logic        store_seen,
    input  logic [31:0] store_addr,
    output logic        rd_req,
    output logic        wr_req,
    output logic [31:0] wr_data,
    output logic [31:0] old_data,
    output logic        done,
    output logic        sc_fail,
    output logic        lock,
    output logic [31:0] locked_address
);

typedef enum logic [1:0] {
    st_idle,
    st_read,    // read issued, waiting for the response
    st_write,   // one cycle, write request goes out
    st_finish   // waiting for the write response
} state_t;

state_t state;
state_t state_next;
logic is_lr;
logic is_sc;
logic sc_ok;
logic launch;
logic [31:0] old_q;   // memory word before the operation
logic [31:0] alu_out;

assign is_lr  = (funct5 == rv32_isa_pkg::amo_lr);
assign is_sc  = (funct5 == rv32_isa_pkg::amo_sc);
assign sc_ok  = lock && (locked_address == word_addr);
assign launch = (state == st_idle) && start;

assign rd_req  = launch && !is_sc;
assign wr_req  = (launch && is_sc && sc_ok) || (state == st_write);
assign sc_fail = launch && is_sc && !sc_ok; // no request at all, done right away
assign done    = sc_fail || ((state == st_read) && resp && is_lr)
               || ((state == st_finish) && resp);

// lr finishes on the read response, before old_q is loaded
assign old_data = (state == st_read) ? rdata : old_q;
assign wr_data  = alu_out;

always_comb
begin
    case (funct5)
        rv32_isa_pkg::amo_add:  alu_out = old_q + operand;
        rv32_isa_pkg::amo_xor:  alu_out = old_q ^ operand;
        rv32_isa_pkg::amo_and:  alu_out = old_q & operand;
        rv32_isa_pkg::amo_or:   alu_out = old_q | operand;
        rv32_isa_pkg::amo_min:  alu_out = ($signed(old_q) < $signed(operand)) ? old_q : operand;
        rv32_isa_pkg::amo_max:  alu_out = ($signed(old_q) > $signed(operand)) ? old_q : operand;
        rv32_isa_pkg::amo_minu: alu_out = (old_q < operand) ? old_q : operand;
        rv32_isa_pkg::amo_maxu: alu_out = (old_q > operand) ? old_q : operand;
        rv32_isa_pkg::amo_swap: alu_out = operand;
        default:                alu_out = operand;  // sc stores rs2 as is
    endcase
end

always_comb
begin
    state_next = state;
    case (state)
        st_idle:
        begin
            if (launch)
            begin
                if (is_sc)
                    state_next = sc_ok ? st_finish : st_idle;
                else
                    state_next = st_read;
            end
        end
        st_read:   if (resp) state_next = is_lr ? st_idle : st_write;
        st_write:  state_next = st_finish;
        st_finish: if (resp) state_next = st_idle;
        default:   state_next = st_idle;
    endcase
end

always_ff @(posedge clk)
begin
    if (rst)
        state <= st_idle;
    else
        state <= state_next;
end

always_ff @(posedge clk)
begin
    if ((state == st_read) && resp)
        old_q <= rdata;
end

// single hart reservation
always_ff @(posedge clk)
begin
    if (rst)
    begin
        lock           <= 1'b0;
        locked_address <= '0;
    end
    else if ((state == st_read) && resp && is_lr)
    begin
        lock           <= 1'b1;
        locked_address <= word_addr;
    end
    else if (launch && is_sc)
        lock <= 1'b0;   // pass or fail, sc consumes it
    else if (store_seen && (store_addr == locked_address))
        lock <= 1'b0;
end

endmodule

// File: verilog/mem_align.sv
`timescale 1ns/10ps

module mem_align (
    input  logic [6:0]                  opcode,
    input  logic [2:0]                  funct3,
    input  logic [4:0]                  funct5,
    input  logic [dmem_pkg::xlen-1:0]   addr,
    input  logic [dmem_pkg::xlen-1:0]   rs2_v,
    input  logic [dmem_pkg::xlen-1:0]   rdata_raw,
    input  logic [dmem_pkg::xlen-1:0]   amo_wdata,
    output logic [dmem_pkg::xlen-1:0]   word_addr,
    output logic [dmem_pkg::mask_w-1:0] rmask,
    output logic [dmem_pkg::mask_w-1:0] wmask,
    output logic [dmem_pkg::xlen-1:0]   wdata,
    output logic [dmem_pkg::xlen-1:0]   load_data
);

logic [1:0]  slide;     // byte offset within the word
logic [7:0]  sel_byte;
logic [15:0] sel_half;

assign word_addr = {addr[dmem_pkg::xlen-1:2], 2'b00};
assign slide     = addr[1:0];

// lanes picked out of the raw word for narrow loads
assign sel_byte = rdata_raw[8*slide +: 8];
assign sel_half = rdata_raw[16*slide[1] +: 16];

always_comb
begin
    rmask = '0;
    wmask = '0;
    wdata = '0;
    case (opcode)
        rv32_isa_pkg::op_load:
        begin
            case (funct3)
                rv32_isa_pkg::f3_lb, rv32_isa_pkg::f3_lbu: rmask = 4'b0001 << slide;
                rv32_isa_pkg::f3_lh, rv32_isa_pkg::f3_lhu: rmask = 4'b0011 << slide;
                rv32_isa_pkg::f3_lw:                       rmask = 4'b1111;
                default:                                   rmask = '0;
            endcase
        end
        rv32_isa_pkg::op_store:
        begin
            // data is replicated, the mask picks the lanes that get written
            case (funct3)
                rv32_isa_pkg::f3_sb:
                begin
                    wmask = 4'b0001 << slide;
                    wdata = {4{rs2_v[7:0]}};
                end
                rv32_isa_pkg::f3_sh:
                begin
                    wmask = 4'b0011 << slide;
                    wdata = {2{rs2_v[15:0]}};
                end
                rv32_isa_pkg::f3_sw:
                begin
                    wmask = 4'b1111;
                    wdata = rs2_v;
                end
                default:
                begin
                    wmask = '0;
                    wdata = '0;
                end
            endcase
        end
        rv32_isa_pkg::op_amo:
        begin
            // atomics are word sized; sc never reads, lr never writes
            rmask = (funct5 == rv32_isa_pkg::amo_sc) ? '0 : '1;
            wmask = (funct5 == rv32_isa_pkg::amo_lr) ? '0 : '1;
            wdata = (funct5 == rv32_isa_pkg::amo_lr) ? '0 : amo_wdata;
        end
        default:
        begin
            rmask = '0;
            wmask = '0;
            wdata = '0;
        end
    endcase
end

// sign or zero extension of the selected lanes
always_comb
begin
    case (funct3)
        rv32_isa_pkg::f3_lb:  load_data = {{(dmem_pkg::xlen-8){sel_byte[7]}}, sel_byte};
        rv32_isa_pkg::f3_lbu: load_data = {{(dmem_pkg::xlen-8){1'b0}}, sel_byte};
        rv32_isa_pkg::f3_lh:  load_data = {{(dmem_pkg::xlen-16){sel_half[15]}}, sel_half};
        rv32_isa_pkg::f3_lhu: load_data = {{(dmem_pkg::xlen-16){1'b0}}, sel_half};
        default:              load_data = rdata_raw; // lw
    endcase
end

endmodule

// File: verilog/dmem_pkg.sv
package dmem_pkg;

    // data and address width of the dmem bus
    localparam int xlen = 32;

    // one enable bit per byte lane
    localparam int mask_w = xlen / 8;

endpackage

// File: verilog/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // major opcodes seen by the memory stage
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_amo   = 7'b0101111;

    // load widths, bit 2 selects zero extension
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // store widths
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // A-extension funct5, instr[31:27]
    localparam logic [4:0] amo_lr   = 5'b00010;
    localparam logic [4:0] amo_sc   = 5'b00011;
    localparam logic [4:0] amo_swap = 5'b00001;
    localparam logic [4:0] amo_add  = 5'b00000;
    localparam logic [4:0] amo_xor  = 5'b00100;
    localparam logic [4:0] amo_and  = 5'b01100;
    localparam logic [4:0] amo_or   = 5'b01000;

    // signed compare group
    localparam logic [4:0] amo_min  = 5'b10000;
    localparam logic [4:0] amo_max  = 5'b10100;

    // unsigned compare group
    localparam logic [4:0] amo_minu = 5'b11000;
    localparam logic [4:0] amo_maxu = 5'b11100;

endpackage
